// File: tb.f
rtl/la_bus_pkg.sv
rtl/la_core_pkg.sv
rtl/cmd_decoder.sv
rtl/la_regs.sv
rtl/trigger_unit.sv
rtl/capture_ctrl.sv
rtl/sample_mem.sv
rtl/reply_encoder.sv
rtl/la_top.sv
testbench/tb_la_top.sv

// File: Bender.yml
package:
  name: la_top

sources:
  - files:
      - rtl/la_bus_pkg.sv
      - rtl/la_core_pkg.sv
      - rtl/cmd_decoder.sv
      - rtl/la_regs.sv
      - rtl/trigger_unit.sv
      - rtl/capture_ctrl.sv
      - rtl/sample_mem.sv
      - rtl/reply_encoder.sv
      - rtl/la_top.sv
  - target: test
    files:
      - testbench/tb_la_top.sv

// File: testbench/tb_la_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_la_top
    import la_bus_pkg::*;
    import la_core_pkg::*;
();

    localparam int ACK_LIMIT  = 500;
    localparam int RSP_LIMIT  = 500;
    localparam int POLL_LIMIT = 100;

    // reply bytes in wire order, index 0 first
    typedef logic [0:6][7:0] reply_t;

    logic       clk = 1'b0;
    logic       rst_i;
    logic       cmd_req_i;
    logic [7:0] cmd_data_i;
    logic       cmd_ack_o;
    logic       rsp_req_o;
    logic [7:0] rsp_data_o;
    logic       rsp_ack_i = 1'b0;
    probe_t     probe_i = '0;

    logic [7:0] rx_q [$];
    int         checks = 0;
    int         errors = 0;
    int         timeouts = 0;

    la_top i_dut (
        .clk, .rst_i, .cmd_req_i, .cmd_data_i, .cmd_ack_o,
        .rsp_req_o, .rsp_data_o, .rsp_ack_i, .probe_i
    );

    always #5 clk = ~clk;

    // probe counts up, strobe is bit 0 of the count
    always @(posedge clk) begin
        probe_i.value  <= probe_i.value + 16'd1;
        probe_i.strobe <= ~probe_i.value[0];
    end

    // host side of the reply channel
    always @(posedge clk) begin
        if (rsp_req_o && !rsp_ack_i) begin
            rx_q.push_back(rsp_data_o);
            rsp_ack_i <= 1'b1;
        end else if (!rsp_req_o && rsp_ack_i) begin
            rsp_ack_i <= 1'b0;
        end
    end

    function automatic logic [7:0] hex_char(input logic [3:0] n);
        string tbl;
        tbl = "0123456789ABCDEF";
        return tbl[n];
    endfunction

    function automatic logic [3:0] hex_nibble(input logic [7:0] c);
        int i;
        hex_nibble = 4'h0;
        for (i = 0; i < 16; i++) begin
            if (hex_char(4'(i)) == c) begin
                hex_nibble = 4'(i);
            end
        end
    endfunction

    // expected reply for a read returning v
    function automatic reply_t reply_bytes(input logic [15:0] v);
        reply_t r;
        r[0] = REPLY_PREAMBLE;
        r[1] = hex_char(v[15:12]);
        r[2] = hex_char(v[11:8]);
        r[3] = hex_char(v[7:4]);
        r[4] = hex_char(v[3:0]);
        r[5] = ASCII_CR;
        r[6] = ASCII_LF;
        return r;
    endfunction

    task automatic end_run();
        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout while waiting for %s", what);
        timeouts++;
        end_run();
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        int n;
        @(posedge clk);
        cmd_req_i  <= 1'b1;
        cmd_data_i <= b;
        n = 0;
        while (!cmd_ack_o) begin
            @(posedge clk);
            n++;
            if (n > ACK_LIMIT) timeout_fail("cmd_ack_o to rise");
        end
        cmd_req_i <= 1'b0;
        n = 0;
        while (cmd_ack_o) begin
            @(posedge clk);
            n++;
            if (n > ACK_LIMIT) timeout_fail("cmd_ack_o to fall");
        end
    endtask

    task automatic send_text(input string s);
        int i;
        for (i = 0; i < s.len(); i++) begin
            send_byte(s[i]);
        end
    endtask

    task automatic send_hex_word(input logic [15:0] w);
        send_byte(hex_char(w[15:12]));
        send_byte(hex_char(w[11:8]));
        send_byte(hex_char(w[7:4]));
        send_byte(hex_char(w[3:0]));
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [15:0] data);
        send_byte(CMD_WRITE);
        send_hex_word(addr);
        send_hex_word(data);
        send_byte(ASCII_CR);
        send_byte(ASCII_LF);
    endtask

    task automatic read_raw(input logic [15:0] addr, output reply_t got);
        int n;
        int i;
        send_byte(CMD_READ);
        send_hex_word(addr);
        send_byte(ASCII_CR);
        send_byte(ASCII_LF);
        n = 0;
        while (rx_q.size() < 7) begin
            @(posedge clk);
            n++;
            if (n > RSP_LIMIT) timeout_fail("a read reply");
        end
        for (i = 0; i < 7; i++) begin
            got[i] = rx_q.pop_front();
        end
    endtask

    task automatic expect_reg(input logic [15:0] addr, input logic [15:0] exp);
        reply_t got;
        reply_t want;
        int     i;
        read_raw(addr, got);
        want = reply_bytes(exp);
        for (i = 0; i < 7; i++) begin
            check_equal("rsp_data_o", 32'(got[i]), 32'(want[i]));
        end
    endtask

    // decodes the digits, then checks the reply framing
    task automatic read_value(input logic [15:0] addr, output logic [15:0] value);
        reply_t got;
        reply_t want;
        int     i;
        read_raw(addr, got);
        value = {hex_nibble(got[1]), hex_nibble(got[2]), hex_nibble(got[3]),
                 hex_nibble(got[4])};
        want  = reply_bytes(value);
        for (i = 0; i < 7; i++) begin
            check_equal("rsp_data_o", 32'(got[i]), 32'(want[i]));
        end
    endtask

    initial begin
        logic [15:0] loc_val;
        logic [15:0] op_val;
        logic [15:0] arg_val;
        logic [15:0] trig_arg;
        logic [15:0] state;
        logic [15:0] wp;
        logic [15:0] val;
        logic [15:0] stb;
        logic [15:0] prev;
        logic        found;
        int          seed_ret;
        int          n;
        int          i;
        int          idx;

        seed_ret   = $urandom(32'hc67a66be);
        rst_i      = 1'b1;
        cmd_req_i  = 1'b0;
        cmd_data_i = 8'h00;
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;
        @(posedge clk);

        expect_reg(REG_STATE, 16'(IDLE));

        // random register values, read back at register width
        loc_val = 16'($urandom());
        op_val  = 16'($urandom());
        arg_val = 16'($urandom());
        write_reg(REG_TRIG_LOC, loc_val);
        write_reg(REG_VALUE_OP, op_val);
        write_reg(REG_VALUE_ARG, arg_val);
        expect_reg(REG_TRIG_LOC, 16'(loc_val[SAMPLE_AW-1:0]));
        expect_reg(REG_VALUE_OP, 16'(op_val[3:0]));
        expect_reg(REG_VALUE_ARG, arg_val);

        // malformed commands are dropped without a reply
        send_text("W0008abcd");
        send_byte(ASCII_CR);
        send_byte(ASCII_LF);
        send_text("R000a");
        send_byte(ASCII_CR);
        send_byte(ASCII_LF);
        send_text("W00010015X");
        send_byte(ASCII_LF);
        send_text("R0007+");
        send_byte(ASCII_LF);
        expect_reg(REG_VALUE_ARG, arg_val);
        expect_reg(REG_TRIG_LOC, 16'(loc_val[SAMPLE_AW-1:0]));

        // capture with an equality trigger a little ahead of the counter
        write_reg(REG_TRIG_LOC, 16'd20);
        write_reg(REG_VALUE_OP, 16'(EQ));
        trig_arg = probe_i.value + 16'd400;
        write_reg(REG_VALUE_ARG, trig_arg);
        write_reg(REG_START, 16'd1);
        n     = 0;
        state = 16'hFFFF;
        while (state != 16'(DONE)) begin
            read_value(REG_STATE, state);
            n++;
            if (n > POLL_LIMIT) timeout_fail("the capture to reach DONE");
        end

        // oldest sample sits at the write pointer
        read_value(REG_WPTR, wp);
        found = 1'b0;
        prev  = '0;
        for (i = 0; i < SAMPLE_DEPTH; i++) begin
            idx = (int'(wp) + i) % SAMPLE_DEPTH;
            read_value(MEM_BASE + 16'(2 * idx), val);
            read_value(MEM_BASE + 16'(2 * idx + 1), stb);
            if (i > 0) begin
                check_equal("sample_value", 32'(val), 32'(prev + 16'd1));
            end
            check_equal("sample_strobe", 32'(stb), 32'(val[0]));
            if (val == trig_arg) found = 1'b1;
            prev = val;
        end
        if (!found) begin
            errors++;
            $display("the trigger value %h is missing from the captured samples", trig_arg);
        end

        write_reg(REG_STOP, 16'd1);
        expect_reg(REG_STATE, 16'(IDLE));

        if (rx_q.size() != 0) begin
            errors++;
            $display("%0d reply bytes arrived that no read asked for", rx_q.size());
        end
        end_run();
    end

endmodule

`default_nettype wire

// File: rtl/la_top.sv
`timescale 1ns/100ps
`default_nettype none

module la_top
    import la_bus_pkg::*;
    import la_core_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  logic       cmd_req_i,
    input  logic [7:0] cmd_data_i,
    output logic       cmd_ack_o,
    output logic       rsp_req_o,
    output logic [7:0] rsp_data_o,
    input  logic       rsp_ack_i,
    input  probe_t     probe_i
);

    // bus chain
    bus_t                 bus_dec;
    bus_t                 bus_regs;
    bus_t                 bus_mem;

    trig_cfg_t            trig_cfg;
    logic [SAMPLE_AW-1:0] trig_loc;
    logic [SAMPLE_AW-1:0] wptr;
    cap_state_e           cap_state;
    logic                 start_req;
    logic                 stop_req;
    logic                 trig;
    logic                 we;
    logic                 reply_busy;

    cmd_decoder i_cmd_decoder (
        .clk, .rst_i, .cmd_req_i, .cmd_data_i, .cmd_ack_o,
        .reply_busy_i(reply_busy),
        .bus_o(bus_dec)
    );

    la_regs i_la_regs (
        .clk, .rst_i,
        .bus_i(bus_dec), .bus_o(bus_regs),
        .cap_state_i(cap_state), .wptr_i(wptr),
        .trig_cfg_o(trig_cfg), .trig_loc_o(trig_loc),
        .start_req_o(start_req), .stop_req_o(stop_req)
    );

    trigger_unit i_trigger_unit (
        .clk, .rst_i, .probe_i,
        .trig_cfg_i(trig_cfg),
        .trig_o(trig)
    );

    capture_ctrl i_capture_ctrl (
        .clk, .rst_i,
        .start_req_i(start_req), .stop_req_i(stop_req),
        .trig_i(trig), .trig_loc_i(trig_loc),
        .state_o(cap_state), .wptr_o(wptr), .we_o(we)
    );

    sample_mem i_sample_mem (
        .clk, .rst_i, .probe_i,
        .we_i(we), .waddr_i(wptr),
        .bus_i(bus_regs), .bus_o(bus_mem)
    );

    reply_encoder i_reply_encoder (
        .clk, .rst_i,
        .bus_i(bus_mem),
        .rsp_req_o, .rsp_data_o, .rsp_ack_i,
        .reply_busy_o(reply_busy)
    );

endmodule

`default_nettype wire

// File: rtl/reply_encoder.sv
`timescale 1ns/100ps
`default_nettype none

module reply_encoder
    import la_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  bus_t       bus_i,
    output logic       rsp_req_o,
    output logic [7:0] rsp_data_o,
    input  logic       rsp_ack_i,
    output logic       reply_busy_o
);

    logic [BUS_DW-1:0] word;
    logic [2:0]        byte_idx;

    // nibble to uppercase ascii
    function automatic logic [7:0] to_hex(input logic [3:0] n);
        return {4'h0, n} + ((n < 4'd10) ? 8'h30 : 8'h37);
    endfunction

    always_comb begin
        case (byte_idx)
            3'd0:    rsp_data_o = REPLY_PREAMBLE;
            3'd1:    rsp_data_o = to_hex(word[15:12]);
            3'd2:    rsp_data_o = to_hex(word[11:8]);
            3'd3:    rsp_data_o = to_hex(word[7:4]);
            3'd4:    rsp_data_o = to_hex(word[3:0]);
            3'd5:    rsp_data_o = ASCII_CR;
            default: rsp_data_o = ASCII_LF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rsp_req_o    <= 1'b0;
            reply_busy_o <= 1'b0;
            byte_idx     <= '0;
        end else if (!reply_busy_o) begin
            if (bus_i.valid && !bus_i.rw) begin
                word         <= bus_i.data;
                byte_idx     <= '0;
                reply_busy_o <= 1'b1;
                rsp_req_o    <= 1'b1;
            end
        end else if (rsp_req_o) begin
            if (rsp_ack_i) begin
                rsp_req_o <= 1'b0;
            end
        end else if (!rsp_ack_i) begin
            // handshake closed, move on or finish after LF
            if (byte_idx == 3'd6) begin
                reply_busy_o <= 1'b0;
            end else begin
                byte_idx  <= byte_idx + 3'd1;
                rsp_req_o <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst_i)
        (rsp_req_o && $past(rsp_req_o)) |-> $stable(rsp_data_o));

endmodule

`default_nettype wire

// File: rtl/sample_mem.sv
`timescale 1ns/100ps
`default_nettype none

module sample_mem
    import la_bus_pkg::*;
    import la_core_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_i,
    input  probe_t               probe_i,
    input  logic                 we_i,
    input  logic [SAMPLE_AW-1:0] waddr_i,
    input  bus_t                 bus_i,
    output bus_t                 bus_o
);

    probe_t            mem [SAMPLE_DEPTH];
    bus_t              pipe [2];
    logic              hit_q [2];
    logic              sel_q [2];
    probe_t            rd_q [2];
    logic [BUS_AW-1:0] offset;

    // addresses below MEM_BASE wrap to large offsets
    assign offset = bus_i.addr - MEM_BASE;

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= probe_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pipe[0].valid <= 1'b0;
            pipe[1].valid <= 1'b0;
            bus_o.valid   <= 1'b0;
            hit_q[0]      <= 1'b0;
            hit_q[1]      <= 1'b0;
        end else begin
            pipe[0]  <= bus_i;
            pipe[1]  <= pipe[0];
            bus_o    <= pipe[1];
            hit_q[0] <= bus_i.valid && !bus_i.rw && (offset < MEM_WORDS);
            hit_q[1] <= hit_q[0];
            if (hit_q[1]) begin
                bus_o.data <= sel_q[1] ? BUS_DW'(rd_q[1].strobe) : rd_q[1].value;
            end
        end
    end

    // read data follows the transaction down the pipe
    always_ff @(posedge clk) begin
        rd_q[0]  <= mem[offset[SAMPLE_AW:1]];
        sel_q[0] <= offset[0];
        rd_q[1]  <= rd_q[0];
        sel_q[1] <= sel_q[0];
    end

endmodule

`default_nettype wire

// File: rtl/capture_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module capture_ctrl
    import la_core_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 start_req_i,
    input  logic                 stop_req_i,
    input  logic                 trig_i,
    input  logic [SAMPLE_AW-1:0] trig_loc_i,
    output cap_state_e           state_o,
    output logic [SAMPLE_AW-1:0] wptr_o,
    output logic                 we_o
);

    logic [SAMPLE_AW-1:0] rptr;
    logic                 start_q;
    logic                 stop_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_o <= IDLE;
            wptr_o  <= '0;
            rptr    <= '0;
            we_o    <= 1'b0;
            start_q <= 1'b0;
            stop_q  <= 1'b0;
        end else begin
            start_q <= start_req_i;
            stop_q  <= stop_req_i;
            case (state_o)
                IDLE: begin
                    wptr_o <= '0;
                    rptr   <= '0;
                    if (start_req_i && !start_q) begin
                        state_o <= FILL;
                        we_o    <= 1'b1;
                    end
                end
                FILL: begin
                    wptr_o <= wptr_o + 1'b1;
                    if (wptr_o == trig_loc_i) begin
                        state_o <= trig_i ? CAPTURING : ARMED;
                    end
                end
                // pre-trigger window slides around the buffer
                ARMED: begin
                    wptr_o <= wptr_o + 1'b1;
                    rptr   <= rptr + 1'b1;
                    if (trig_i) begin
                        state_o <= CAPTURING;
                    end
                end
                // stop with wptr on the oldest sample
                CAPTURING: begin
                    wptr_o <= wptr_o + 1'b1;
                    if (wptr_o + 1'b1 == rptr) begin
                        we_o    <= 1'b0;
                        state_o <= DONE;
                    end
                end
                default: begin
                end
            endcase
            if (stop_req_i && !stop_q) begin
                state_o <= IDLE;
                we_o    <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst_i)
        (state_o inside {IDLE, DONE}) |-> !we_o);

endmodule

`default_nettype wire

// File: rtl/trigger_unit.sv
`timescale 1ns/100ps
`default_nettype none

module trigger_unit
    import la_core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  probe_t    probe_i,
    input  trig_cfg_t trig_cfg_i,
    output logic      trig_o
);

    probe_t probe_prev;
    logic   strobe_hit;
    logic   value_hit;

    // edge ops look at the previous sample, compare ops at arg
    function automatic logic eval_op(input trig_op_e op, input logic [PROBE_VW-1:0] cur,
                                     input logic [PROBE_VW-1:0] prev,
                                     input logic [PROBE_VW-1:0] arg);
        case (op)
            RISING:   return cur > prev;
            FALLING:  return cur < prev;
            CHANGING: return cur != prev;
            GT:       return cur > arg;
            LT:       return cur < arg;
            GEQ:      return cur >= arg;
            LEQ:      return cur <= arg;
            EQ:       return cur == arg;
            NEQ:      return cur != arg;
            default:  return 1'b0;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            probe_prev <= '0;
        end else begin
            probe_prev <= probe_i;
        end
    end

    // strobe widened so one compare serves both probes
    assign strobe_hit = eval_op(trig_cfg_i.strobe_op, PROBE_VW'(probe_i.strobe),
                                PROBE_VW'(probe_prev.strobe), PROBE_VW'(trig_cfg_i.strobe_arg));
    assign value_hit  = eval_op(trig_cfg_i.value_op, probe_i.value, probe_prev.value,
                                trig_cfg_i.value_arg);
    assign trig_o     = strobe_hit || value_hit;

endmodule

`default_nettype wire

// File: rtl/la_regs.sv
`timescale 1ns/100ps
`default_nettype none

module la_regs
    import la_bus_pkg::*;
    import la_core_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_i,
    input  bus_t                 bus_i,
    output bus_t                 bus_o,
    input  cap_state_e           cap_state_i,
    input  logic [SAMPLE_AW-1:0] wptr_i,
    output trig_cfg_t            trig_cfg_o,
    output logic [SAMPLE_AW-1:0] trig_loc_o,
    output logic                 start_req_o,
    output logic                 stop_req_o
);

    logic [BUS_DW-1:0] rdata;
    logic              hit;

    // read mux over the register map
    always_comb begin
        hit   = 1'b1;
        rdata = '0;
        case (bus_i.addr)
            REG_STATE:      rdata = BUS_DW'(cap_state_i);
            REG_TRIG_LOC:   rdata = BUS_DW'(trig_loc_o);
            REG_START:      rdata = BUS_DW'(start_req_o);
            REG_STOP:       rdata = BUS_DW'(stop_req_o);
            REG_WPTR:       rdata = BUS_DW'(wptr_i);
            REG_STROBE_OP:  rdata = BUS_DW'(trig_cfg_o.strobe_op);
            REG_STROBE_ARG: rdata = BUS_DW'(trig_cfg_o.strobe_arg);
            REG_VALUE_OP:   rdata = BUS_DW'(trig_cfg_o.value_op);
            REG_VALUE_ARG:  rdata = BUS_DW'(trig_cfg_o.value_arg);
            default:        hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            bus_o.valid <= 1'b0;
            trig_cfg_o  <= '0;
            trig_loc_o  <= '0;
            start_req_o <= 1'b0;
            stop_req_o  <= 1'b0;
        end else begin
            bus_o <= bus_i;
            if (bus_i.valid && !bus_i.rw && hit) begin
                bus_o.data <= rdata;
            end
            // writes are truncated to the register width
            if (bus_i.valid && bus_i.rw) begin
                case (bus_i.addr)
                    REG_TRIG_LOC:   trig_loc_o <= bus_i.data[SAMPLE_AW-1:0];
                    REG_START:      start_req_o <= bus_i.data[0];
                    REG_STOP:       stop_req_o <= bus_i.data[0];
                    REG_STROBE_OP:  trig_cfg_o.strobe_op <= trig_op_e'(bus_i.data[3:0]);
                    REG_STROBE_ARG: trig_cfg_o.strobe_arg <= bus_i.data[0];
                    REG_VALUE_OP:   trig_cfg_o.value_op <= trig_op_e'(bus_i.data[3:0]);
                    REG_VALUE_ARG:  trig_cfg_o.value_arg <= bus_i.data[PROBE_VW-1:0];
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/cmd_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_decoder
    import la_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  logic       cmd_req_i,
    input  logic [7:0] cmd_data_i,
    output logic       cmd_ack_o,
    input  logic       reply_busy_i,
    output bus_t       bus_o
);

    typedef enum logic [1:0] {IDLE, READ, WRITE} dec_state_e;

    dec_state_e  state;
    logic [3:0]  byte_cnt;
    logic [31:0] digits;
    logic        take;
    logic        is_term;
    logic        last_byte;

    // uppercase hex only
    function automatic logic is_hex(input logic [7:0] c);
        return ((c >= "0") && (c <= "9")) || ((c >= "A") && (c <= "F"));
    endfunction

    function automatic logic [3:0] hex_val(input logic [7:0] c);
        logic [7:0] v;
        v = (c <= "9") ? (c - 8'h30) : (c - 8'h37);
        return v[3:0];
    endfunction

    // new byte accepted in the cycle ack rises
    assign take      = cmd_req_i && !cmd_ack_o && !reply_busy_i;
    assign is_term   = (cmd_data_i == ASCII_CR) || (cmd_data_i == ASCII_LF);
    assign last_byte = ((state == READ) && (byte_cnt == 4'd4)) ||
                       ((state == WRITE) && (byte_cnt == 4'd8));

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cmd_ack_o   <= 1'b0;
            state       <= IDLE;
            byte_cnt    <= '0;
            bus_o.valid <= 1'b0;
        end else begin
            bus_o.valid <= 1'b0;
            if (take) begin
                cmd_ack_o <= 1'b1;
            end else if (!cmd_req_i) begin
                cmd_ack_o <= 1'b0;
            end

            if (take) begin
                if (state == IDLE) begin
                    byte_cnt <= '0;
                    if (cmd_data_i == CMD_READ) begin
                        state <= READ;
                    end else if (cmd_data_i == CMD_WRITE) begin
                        state <= WRITE;
                    end
                end else if (last_byte) begin
                    state <= IDLE;
                    if (is_term) begin
                        bus_o.valid <= 1'b1;
                        bus_o.rw    <= (state == WRITE);
                        bus_o.addr  <= (state == WRITE) ? digits[31:16] : digits[15:0];
                        bus_o.data  <= (state == WRITE) ? digits[15:0] : '0;
                    end
                end else if (is_hex(cmd_data_i)) begin
                    digits   <= {digits[27:0], hex_val(cmd_data_i)};
                    byte_cnt <= byte_cnt + 4'd1;
                end else begin
                    // malformed digit, drop the command
                    state <= IDLE;
                end
            end
        end
    end

    // commands are separated by several handshakes
    assert property (@(posedge clk) disable iff (rst_i) bus_o.valid |=> !bus_o.valid);

endmodule

`default_nettype wire

// File: rtl/la_core_pkg.sv
`default_nettype none

package la_core_pkg;

    localparam int SAMPLE_DEPTH = 64;
    localparam int SAMPLE_AW    = 6;
    // even word holds the value, odd word the strobe
    localparam int MEM_WORDS    = 2 * SAMPLE_DEPTH;
    localparam int PROBE_VW     = 16;

    typedef struct packed {
        logic                strobe;
        logic [PROBE_VW-1:0] value;
    } probe_t;

    typedef enum logic [3:0] {
        DISABLE,
        RISING,
        FALLING,
        CHANGING,
        GT,
        LT,
        GEQ,
        LEQ,
        EQ,
        NEQ
    } trig_op_e;

    typedef struct packed {
        trig_op_e            strobe_op;
        logic                strobe_arg;
        trig_op_e            value_op;
        logic [PROBE_VW-1:0] value_arg;
    } trig_cfg_t;

    typedef enum logic [2:0] {
        IDLE,
        FILL,
        ARMED,
        CAPTURING,
        DONE
    } cap_state_e;

endpackage

`default_nettype wire

// File: rtl/la_bus_pkg.sv
`default_nettype none

package la_bus_pkg;

    localparam int BUS_AW = 16;
    localparam int BUS_DW = 16;

    // one register-bus transaction, rw high for a write
    typedef struct packed {
        logic [BUS_AW-1:0] addr;
        logic [BUS_DW-1:0] data;
        logic              rw;
        logic              valid;
    } bus_t;

    // ascii command protocol
    localparam logic [7:0] ASCII_CR       = 8'h0D;
    localparam logic [7:0] ASCII_LF       = 8'h0A;
    localparam logic [7:0] CMD_READ       = "R";
    localparam logic [7:0] CMD_WRITE      = "W";
    localparam logic [7:0] REPLY_PREAMBLE = "D";

    // register map
    localparam logic [BUS_AW-1:0] REG_STATE      = 16'd0;
    localparam logic [BUS_AW-1:0] REG_TRIG_LOC   = 16'd1;
    localparam logic [BUS_AW-1:0] REG_START      = 16'd2;
    localparam logic [BUS_AW-1:0] REG_STOP       = 16'd3;
    localparam logic [BUS_AW-1:0] REG_WPTR       = 16'd4;
    localparam logic [BUS_AW-1:0] REG_STROBE_OP  = 16'd5;
    localparam logic [BUS_AW-1:0] REG_STROBE_ARG = 16'd6;
    localparam logic [BUS_AW-1:0] REG_VALUE_OP   = 16'd7;
    localparam logic [BUS_AW-1:0] REG_VALUE_ARG  = 16'd8;
    localparam logic [BUS_AW-1:0] MEM_BASE       = 16'd16;

endpackage

`default_nettype wire
